// ==== verilog/io_pkg.sv ====
package io_pkg;

    // AXI4-Lite bus geometry
    localparam int axi_addr_w = 4;   // 16 bytes of register space
    localparam int axi_data_w = 32;

    // Register map, byte offsets

    // Debounced levels, read only
    localparam logic [axi_addr_w-1:0] reg_level_off = 4'h0;

    // Sticky rising-edge flags, write 1 to clear
    localparam logic [axi_addr_w-1:0] reg_rise_off = 4'h4;

    // Sticky falling-edge flags, write 1 to clear
    localparam logic [axi_addr_w-1:0] reg_fall_off = 4'h8;

    // LED output register, read/write
    localparam logic [axi_addr_w-1:0] reg_led_off = 4'hC;

    // AXI response codes
    localparam logic [1:0] resp_okay   = 2'b00;
    localparam logic [1:0] resp_slverr = 2'b10;

    // Board indicators
    localparam int led_w = 8;

endpackage

// ==== verilog/chan_if.sv ====
`timescale 1ns/1ns

// Per-line bundle between synchronizer, debounce channel and register block
interface chan_if;

    logic in_bit;  // Synchronized raw line
    logic tick;    // Shared sample strobe, one cycle wide
    logic level;   // Debounced level
    logic rise;    // One-cycle pulse on 0 -> 1
    logic fall;    // One-cycle pulse on 1 -> 0

    // Synchronizer side
    modport feed (output in_bit, output tick);

    // Debounce filter
    modport result (
        input  in_bit,
        input  tick,
        output level,
        output rise,
        output fall
    );

    // Register block only sees results
    modport drain (input level, input rise, input fall);

endinterface

// ==== verilog/gpio_sync.sv ====
`timescale 1ns/1ns

module gpio_sync #(
    parameter int width       = 9,
    parameter int sync_stages = 2,      // Flops per line, at least 1
    parameter int rate        = 125000  // Clock cycles per sample tick
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic [width-1:0] gpio_in,
    chan_if.feed             chans [width]
);

    // Counter wide enough for rate-1
    localparam int cnt_w = (rate > 1) ? $clog2(rate) : 1;

    logic [width-1:0] sync_q [sync_stages];  // Index 0 takes the pins
    logic [cnt_w-1:0] rate_cnt;
    logic             tick_q;

    // Metastability chain, all lines in parallel
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int s = 0; s < sync_stages; s++) begin
                sync_q[s] <= '0;
            end
        end else begin
            sync_q[0] <= gpio_in;
            for (int s = 1; s < sync_stages; s++) begin
                sync_q[s] <= sync_q[s-1];  // Shift toward the oldest stage
            end
        end
    end

    // Rate divider
    // First tick lands rate cycles out of reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rate_cnt <= '0;
            tick_q   <= 1'b0;
        end else if (rate_cnt == cnt_w'(rate - 1)) begin
            rate_cnt <= '0;
            tick_q   <= 1'b1;  // Wrap
        end else begin
            rate_cnt <= rate_cnt + 1'b1;
            tick_q   <= 1'b0;
        end
    end

    // Fan out to channels
    for (genvar i = 0; i < width; i++) begin : g_feed
        assign chans[i].in_bit = sync_q[sync_stages-1][i];  // Oldest stage
        assign chans[i].tick   = tick_q;                    // Same tick for all
    end

endmodule

// ==== verilog/debounce_channel.sv ====
`timescale 1ns/1ns

module debounce_channel #(
    parameter int debounce_n = 4  // Equal samples needed, at least 2
) (
    input  logic    clk,
    input  logic    rst_n,
    chan_if.result  ch
);

    logic [debounce_n-1:0] hist;       // Newest sample in bit 0
    logic [debounce_n-1:0] hist_next;
    logic                  all_high;
    logic                  all_low;
    logic                  level_q;
    logic                  rise_q;
    logic                  fall_q;

    // History as it will look after this tick
    assign hist_next = {hist[debounce_n-2:0], ch.in_bit};
    assign all_high  = &hist_next;
    assign all_low   = ~|hist_next;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hist    <= '0;
            level_q <= 1'b0;
            rise_q  <= 1'b0;
            fall_q  <= 1'b0;
        end else begin
            // Pulses last one cycle only
            rise_q <= 1'b0;
            fall_q <= 1'b0;
            if (ch.tick) begin
                hist <= hist_next;
                if (all_high && !level_q) begin
                    level_q <= 1'b1;
                    rise_q  <= 1'b1;  // Settled high
                end else if (all_low && level_q) begin
                    level_q <= 1'b0;
                    fall_q  <= 1'b1;  // Settled low
                end
            end
        end
    end

    // Mixed history keeps the old level, so glitches shorter than
    // debounce_n ticks never reach the outputs

    assign ch.level = level_q;
    assign ch.rise  = rise_q;
    assign ch.fall  = fall_q;

endmodule

// ==== verilog/gpio_regs.sv ====
`timescale 1ns/1ns

module gpio_regs #(
    parameter int width = 9  // At most axi_data_w
) (
    input  logic                              clk,
    input  logic                              rst_n,
    chan_if.drain                             chans [width],
    output logic [io_pkg::led_w-1:0]          led,
    // Write address / data
    input  logic [io_pkg::axi_addr_w-1:0]     s_axi_awaddr,
    input  logic                              s_axi_awvalid,
    output logic                              s_axi_awready,
    input  logic [io_pkg::axi_data_w-1:0]     s_axi_wdata,
    input  logic [io_pkg::axi_data_w/8-1:0]   s_axi_wstrb,
    input  logic                              s_axi_wvalid,
    output logic                              s_axi_wready,
    // Write response
    output logic [1:0]                        s_axi_bresp,
    output logic                              s_axi_bvalid,
    input  logic                              s_axi_bready,
    // Read
    input  logic [io_pkg::axi_addr_w-1:0]     s_axi_araddr,
    input  logic                              s_axi_arvalid,
    output logic                              s_axi_arready,
    output logic [io_pkg::axi_data_w-1:0]     s_axi_rdata,
    output logic [1:0]                        s_axi_rresp,
    output logic                              s_axi_rvalid,
    input  logic                              s_axi_rready
);

    import io_pkg::*;

    localparam int strb_w = axi_data_w / 8;

    logic [width-1:0]      level_vec;
    logic [width-1:0]      rise_vec;
    logic [width-1:0]      fall_vec;
    logic [width-1:0]      rise_flags;   // Sticky
    logic [width-1:0]      fall_flags;   // Sticky
    logic [axi_data_w-1:0] led_reg;
    logic                  wr_start;
    logic                  rd_start;
    logic                  wr_en;
    logic                  rd_en;
    logic                  wr_err;
    logic                  led_wr;
    logic [width-1:0]      rise_clr;
    logic [width-1:0]      fall_clr;
    logic [axi_data_w-1:0] rd_word;
    logic                  rd_err;

    // Gather channel results into vectors
    for (genvar i = 0; i < width; i++) begin : g_drain
        assign level_vec[i] = chans[i].level;
        assign rise_vec[i]  = chans[i].rise;
        assign fall_vec[i]  = chans[i].fall;
    end

    // Take a new request only while no response is pending
    assign wr_start = s_axi_awvalid && s_axi_wvalid && !s_axi_bvalid && !s_axi_awready;
    assign rd_start = s_axi_arvalid && !s_axi_rvalid && !s_axi_arready;
    assign wr_en    = s_axi_awready && s_axi_awvalid && s_axi_wvalid;  // Handshake cycle
    assign rd_en    = s_axi_arready && s_axi_arvalid;

    // Write decode
    always_comb begin
        wr_err   = 1'b0;
        led_wr   = 1'b0;
        rise_clr = '0;
        fall_clr = '0;
        if (wr_en) begin
            case (s_axi_awaddr)
                reg_rise_off: rise_clr = s_axi_wdata[width-1:0];  // Strobes ignored
                reg_fall_off: fall_clr = s_axi_wdata[width-1:0];
                reg_led_off:  led_wr   = 1'b1;
                default:      wr_err   = 1'b1;  // Level reg and holes
            endcase
        end
    end

    // Read decode
    always_comb begin
        rd_word = '0;
        rd_err  = 1'b0;
        case (s_axi_araddr)
            reg_level_off: rd_word[width-1:0] = level_vec;
            reg_rise_off:  rd_word[width-1:0] = rise_flags;
            reg_fall_off:  rd_word[width-1:0] = fall_flags;
            reg_led_off:   rd_word            = led_reg;
            default:       rd_err             = 1'b1;  // Reads as zero
        endcase
    end

    // Handshake state
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s_axi_awready <= 1'b0;
            s_axi_wready  <= 1'b0;
            s_axi_bvalid  <= 1'b0;
            s_axi_arready <= 1'b0;
            s_axi_rvalid  <= 1'b0;
        end else begin
            s_axi_awready <= wr_start;  // One-cycle pulse, both together
            s_axi_wready  <= wr_start;
            s_axi_arready <= rd_start;
            if (wr_en) begin
                s_axi_bvalid <= 1'b1;
            end else if (s_axi_bready) begin
                s_axi_bvalid <= 1'b0;
            end
            if (rd_en) begin
                s_axi_rvalid <= 1'b1;
            end else if (s_axi_rready) begin
                s_axi_rvalid <= 1'b0;
            end
        end
    end

    // Response payload, held while valid is up
    always_ff @(posedge clk) begin
        if (wr_en) begin
            s_axi_bresp <= wr_err ? resp_slverr : resp_okay;
        end
        if (rd_en) begin
            s_axi_rdata <= rd_word;
            s_axi_rresp <= rd_err ? resp_slverr : resp_okay;
        end
    end

    // Flags and LED register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rise_flags <= '0;
            fall_flags <= '0;
            led_reg    <= '0;
        end else begin
            rise_flags <= (rise_flags & ~rise_clr) | rise_vec;  // New edge beats clear
            fall_flags <= (fall_flags & ~fall_clr) | fall_vec;
            if (led_wr) begin
                for (int b = 0; b < strb_w; b++) begin
                    if (s_axi_wstrb[b]) begin
                        led_reg[b*8 +: 8] <= s_axi_wdata[b*8 +: 8];  // Byte merge
                    end
                end
            end
        end
    end

    assign led = led_reg[led_w-1:0];

endmodule

// ==== verilog/board_io_top.sv ====
`timescale 1ns/1ns

module board_io_top #(
    parameter int width       = 9,      // Buttons plus switches, at most 32
    parameter int sync_stages = 2,
    parameter int debounce_n  = 4,
    parameter int rate        = 125000  // 1 ms samples at 125 MHz
) (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [width-1:0]                  gpio_in,
    output logic [io_pkg::led_w-1:0]          led,
    input  logic [io_pkg::axi_addr_w-1:0]     s_axi_awaddr,
    input  logic                              s_axi_awvalid,
    output logic                              s_axi_awready,
    input  logic [io_pkg::axi_data_w-1:0]     s_axi_wdata,
    input  logic [io_pkg::axi_data_w/8-1:0]   s_axi_wstrb,
    input  logic                              s_axi_wvalid,
    output logic                              s_axi_wready,
    output logic [1:0]                        s_axi_bresp,
    output logic                              s_axi_bvalid,
    input  logic                              s_axi_bready,
    input  logic [io_pkg::axi_addr_w-1:0]     s_axi_araddr,
    input  logic                              s_axi_arvalid,
    output logic                              s_axi_arready,
    output logic [io_pkg::axi_data_w-1:0]     s_axi_rdata,
    output logic [1:0]                        s_axi_rresp,
    output logic                              s_axi_rvalid,
    input  logic                              s_axi_rready
);

    // One bundle per input line
    chan_if chans [width] ();

    // Raw pins to synchronized bits plus sample tick
    gpio_sync #(
        .width       (width),
        .sync_stages (sync_stages),
        .rate        (rate)
    ) gpio_sync_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .gpio_in (gpio_in),
        .chans   (chans)
    );

    // Identical filter per line
    for (genvar i = 0; i < width; i++) begin : g_chan
        debounce_channel #(
            .debounce_n (debounce_n)
        ) debounce_channel_i (
            .clk   (clk),
            .rst_n (rst_n),
            .ch    (chans[i])
        );
    end

    gpio_regs #(
        .width (width)
    ) gpio_regs_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .chans         (chans),
        .led           (led),
        .s_axi_awaddr  (s_axi_awaddr),
        .s_axi_awvalid (s_axi_awvalid),
        .s_axi_awready (s_axi_awready),
        .s_axi_wdata   (s_axi_wdata),
        .s_axi_wstrb   (s_axi_wstrb),
        .s_axi_wvalid  (s_axi_wvalid),
        .s_axi_wready  (s_axi_wready),
        .s_axi_bresp   (s_axi_bresp),
        .s_axi_bvalid  (s_axi_bvalid),
        .s_axi_bready  (s_axi_bready),
        .s_axi_araddr  (s_axi_araddr),
        .s_axi_arvalid (s_axi_arvalid),
        .s_axi_arready (s_axi_arready),
        .s_axi_rdata   (s_axi_rdata),
        .s_axi_rresp   (s_axi_rresp),
        .s_axi_rvalid  (s_axi_rvalid),
        .s_axi_rready  (s_axi_rready)
    );

endmodule

// ==== testbench/board_io_asserts.sv ====
`timescale 1ns/1ns

// AXI4-Lite slave handshake rules
module board_io_asserts (
    input logic clk,
    input logic rst_n,
    input logic s_axi_awready,
    input logic s_axi_wready,
    input logic s_axi_bvalid,
    input logic s_axi_bready,
    input logic s_axi_rvalid,
    input logic s_axi_rready
);

    // Write response waits for the master
    bvalid_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid
    ) else $error("bvalid dropped before bready");

    rvalid_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        s_axi_rvalid && !s_axi_rready |=> s_axi_rvalid
    ) else $error("rvalid dropped before rready");

    // Address and data taken together, never over a held response
    ready_pair: assert property (
        @(posedge clk) disable iff (!rst_n)
        (s_axi_awready || s_axi_wready) |-> s_axi_awready && s_axi_wready && !s_axi_bvalid
    ) else $error("awready and wready out of step or raised while bvalid held");

    // Single-cycle pulse
    ready_pulse: assert property (
        @(posedge clk) disable iff (!rst_n)
        s_axi_awready |=> !s_axi_awready && !s_axi_wready
    ) else $error("awready and wready held longer than one cycle");

endmodule

bind gpio_regs board_io_asserts asserts_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .s_axi_awready (s_axi_awready),
    .s_axi_wready  (s_axi_wready),
    .s_axi_bvalid  (s_axi_bvalid),
    .s_axi_bready  (s_axi_bready),
    .s_axi_rvalid  (s_axi_rvalid),
    .s_axi_rready  (s_axi_rready)
);

// ==== testbench/tb_board_io.sv ====
`timescale 1ns/1ns

module tb_board_io;

    import io_pkg::*;

    localparam int width       = 9;
    localparam int rate        = 4;
    localparam int debounce_n  = 4;
    localparam int sync_stages = 2;
    localparam int n_rows      = 4;
    localparam int settle      = 24;    // Above debounce_n*rate + sync_stages + 2
    localparam int margin      = 1000;  // Cycles for AXI traffic and reset

    typedef struct packed {
        logic [width-1:0] gpio;   // Input pattern held on the pins
        int               hold;   // Cycles to hold it
        logic [31:0]      level;  // Settled level
        logic [31:0]      rise;   // Rise mask accumulated since reset
        logic [31:0]      fall;   // Fall mask, same
    } row_t;

    row_t rows [n_rows] = '{
        '{9'h0A5, settle, 32'h0A5, 32'h0A5, 32'h000},
        '{9'h15A, settle, 32'h15A, 32'h1FF, 32'h0A5},  // Every bit flips
        '{9'h1F0, settle, 32'h1F0, 32'h1FF, 32'h0AF},
        '{9'h000, settle, 32'h000, 32'h1FF, 32'h1FF}   // All fall
    };

    logic                  clk;
    logic                  rst_n;
    logic [width-1:0]      gpio_in;
    logic [led_w-1:0]      led;
    logic [axi_addr_w-1:0] s_axi_awaddr;
    logic                  s_axi_awvalid;
    logic                  s_axi_awready;
    logic [axi_data_w-1:0] s_axi_wdata;
    logic [3:0]            s_axi_wstrb;
    logic                  s_axi_wvalid;
    logic                  s_axi_wready;
    logic [1:0]            s_axi_bresp;
    logic                  s_axi_bvalid;
    logic                  s_axi_bready;
    logic [axi_addr_w-1:0] s_axi_araddr;
    logic                  s_axi_arvalid;
    logic                  s_axi_arready;
    logic [axi_data_w-1:0] s_axi_rdata;
    logic [1:0]            s_axi_rresp;
    logic                  s_axi_rvalid;
    logic                  s_axi_rready;
    int                    n_checks = 0;
    int                    n_errors = 0;

    board_io_top #(
        .width       (width),
        .sync_stages (sync_stages),
        .debounce_n  (debounce_n),
        .rate        (rate)
    ) dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;  // 100 ns period
    end

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("ERR %0t %s got 0x%0h expected 0x%0h", $time, name, got, exp);
        end
    endtask

    task automatic axi_write(input logic [3:0] addr, input logic [31:0] data,
                             input logic [3:0] strb, input int bdelay,
                             output logic [1:0] resp);
        s_axi_awaddr  = addr;
        s_axi_wdata   = data;
        s_axi_wstrb   = strb;
        s_axi_awvalid = 1'b1;
        s_axi_wvalid  = 1'b1;
        @(negedge clk);
        while (!s_axi_awready) @(negedge clk);
        check("s_axi_wready", 32'(s_axi_wready), 32'h1);
        @(negedge clk);  // Handshake taken on the edge just passed
        s_axi_awvalid = 1'b0;
        s_axi_wvalid  = 1'b0;
        repeat (bdelay) begin
            @(negedge clk);
            check("s_axi_bvalid", 32'(s_axi_bvalid), 32'h1);  // Held without bready
        end
        while (!s_axi_bvalid) @(negedge clk);
        resp = s_axi_bresp;
        s_axi_bready = 1'b1;
        @(negedge clk);
        s_axi_bready = 1'b0;
    endtask

    task automatic axi_read(input logic [3:0] addr, input int rdelay,
                            output logic [31:0] data, output logic [1:0] resp);
        logic [31:0] first;
        s_axi_araddr  = addr;
        s_axi_arvalid = 1'b1;
        @(negedge clk);
        while (!s_axi_arready) @(negedge clk);
        @(negedge clk);
        s_axi_arvalid = 1'b0;
        first = s_axi_rdata;
        repeat (rdelay) begin
            @(negedge clk);
            check("s_axi_rvalid", 32'(s_axi_rvalid), 32'h1);
            check("s_axi_rdata", s_axi_rdata, first);  // Data frozen too
        end
        while (!s_axi_rvalid) @(negedge clk);
        data = s_axi_rdata;
        resp = s_axi_rresp;
        s_axi_rready = 1'b1;
        @(negedge clk);
        s_axi_rready = 1'b0;
    endtask

    // Read with an OKAY response expected
    task automatic read_expect(input logic [3:0] addr, input logic [31:0] exp, input string name);
        logic [31:0] data;
        logic [1:0]  resp;
        axi_read(addr, 0, data, resp);
        check(name, data, exp);
        check("s_axi_rresp", 32'(resp), 32'(resp_okay));
    endtask

    // Watchdog sized from the table
    initial begin
        int budget;
        budget = settle + rate * (rate + 1) + margin;  // Spikes, glitch wait and bus traffic
        for (int r = 0; r < n_rows; r++) begin
            budget += rows[r].hold;
        end
        repeat (budget) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the DUT stopped responding", budget);
        $display("Test failures found");
        $finish;
    end

    initial begin
        logic [31:0] data;
        logic [31:0] led_model;
        logic [3:0]  strb;
        logic [1:0]  resp;
        void'($urandom(48));
        rst_n         = 1'b0;
        gpio_in       = '0;
        s_axi_awaddr  = '0;
        s_axi_awvalid = 1'b0;
        s_axi_wdata   = '0;
        s_axi_wstrb   = '0;
        s_axi_wvalid  = 1'b0;
        s_axi_bready  = 1'b0;
        s_axi_araddr  = '0;
        s_axi_arvalid = 1'b0;
        s_axi_rready  = 1'b0;
        led_model     = '0;
        repeat (5) @(negedge clk);
        rst_n = 1'b1;

        // Everything clear out of reset
        check("led", 32'(led), 32'h0);
        read_expect(reg_level_off, 32'h0, "reg_level");
        read_expect(reg_rise_off, 32'h0, "reg_rise");
        read_expect(reg_fall_off, 32'h0, "reg_fall");
        read_expect(reg_led_off, 32'h0, "reg_led");

        for (int r = 0; r < n_rows; r++) begin
            gpio_in = rows[r].gpio;
            repeat (rows[r].hold) @(negedge clk);
            read_expect(reg_level_off, rows[r].level, "reg_level");
            read_expect(reg_rise_off, rows[r].rise, "reg_rise");
            read_expect(reg_fall_off, rows[r].fall, "reg_fall");
        end

        // W1C, strobes do not matter for flags
        axi_write(reg_rise_off, 32'h0F0, 4'h0, 0, resp);
        check("s_axi_bresp", 32'(resp), 32'(resp_okay));
        axi_write(reg_fall_off, 32'h055, 4'hF, 0, resp);
        check("s_axi_bresp", 32'(resp), 32'(resp_okay));
        read_expect(reg_rise_off, 32'h10F, "reg_rise");
        read_expect(reg_fall_off, 32'h1AA, "reg_fall");

        // One-cycle spikes on line 4, spaced so each tick phase is hit once
        for (int p = 0; p < rate; p++) begin
            gpio_in = 9'h010;
            @(negedge clk);
            gpio_in = '0;
            repeat (rate) @(negedge clk);
        end
        repeat (settle) @(negedge clk);
        read_expect(reg_level_off, 32'h0, "reg_level");
        read_expect(reg_rise_off, 32'h10F, "reg_rise");
        read_expect(reg_fall_off, 32'h1AA, "reg_fall");

        // Random LED bytes, partial strobes
        for (int k = 0; k < 8; k++) begin
            data = $urandom;
            strb = 4'($urandom);
            for (int b = 0; b < 4; b++) begin
                if (strb[b]) begin
                    led_model[b*8 +: 8] = data[b*8 +: 8];
                end
            end
            axi_write(reg_led_off, data, strb, k % 3, resp);
            check("s_axi_bresp", 32'(resp), 32'(resp_okay));
            check("led", 32'(led), 32'(led_model[7:0]));
            read_expect(reg_led_off, led_model, "reg_led");
        end

        // Error responses, slow bready and rready
        axi_write(reg_level_off, 32'hFFFF_FFFF, 4'hF, 3, resp);
        check("s_axi_bresp", 32'(resp), 32'(resp_slverr));
        axi_write(4'h6, 32'hFFFF_FFFF, 4'hF, 0, resp);  // Hole in the map
        check("s_axi_bresp", 32'(resp), 32'(resp_slverr));
        axi_read(4'h6, 3, data, resp);
        check("s_axi_rdata", data, 32'h0);
        check("s_axi_rresp", 32'(resp), 32'(resp_slverr));
        read_expect(reg_level_off, 32'h0, "reg_level");
        read_expect(reg_rise_off, 32'h10F, "reg_rise");
        read_expect(reg_fall_off, 32'h1AA, "reg_fall");
        read_expect(reg_led_off, led_model, "reg_led");
        check("led", 32'(led), 32'(led_model[7:0]));

        $display("Checks run: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== all.f ====
verilog/io_pkg.sv
verilog/chan_if.sv
verilog/gpio_sync.sv
verilog/debounce_channel.sv
verilog/gpio_regs.sv
verilog/board_io_top.sv
testbench/board_io_asserts.sv
testbench/tb_board_io.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the board IO testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_board_io -f all.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_board_io)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qxF 'All tests passed!'; then
    exit 0
fi
exit 1
